/* Bender.yml */
package:
  name: camera_vision

sources:
  - verilog/cam_pkg.sv
  - verilog/drive_pkg.sv
  - verilog/ov7670_capture.sv
  - verilog/frame_buffer.sv
  - verilog/vga_timing.sv
  - verilog/pixel_reader.sv
  - verilog/target_finder.sv
  - verilog/target_locator.sv
  - verilog/drive_controller.sv
  - verilog/camera_vision_top.sv
  - target: simulation
    files:
      - bench/tb_camera_vision.sv

/* bench/tb_camera_vision.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_camera_vision;

  localparam int FRAME_W    = 24;
  localparam int FRAME_H    = 12;
  localparam int FRAME_PIX  = FRAME_W * FRAME_H;
  localparam int THIRD_W    = FRAME_W / 3;
  localparam int ORANGE_MIN = 6;
  localparam int H_FRONT    = 2;
  localparam int H_SYNC     = 4;
  localparam int H_BACK     = 2;
  localparam int V_FRONT    = 1;
  localparam int V_SYNC     = 2;
  localparam int V_BACK     = 1;
  // Lines per displayed frame, one hsync pulse each
  localparam int V_TOTAL    = FRAME_H + V_FRONT + V_SYNC + V_BACK;
  // Longest wait in clk_50 cycles
  // A displayed frame takes 1024
  localparam int TIMEOUT    = 3000;

  logic              clk_50;
  logic              reset;
  logic              cam_vsync;
  logic              cam_href;
  logic              cam_pclk_en;
  logic [7:0]        cam_data;
  logic              cmd_strobe;
  drive_pkg::cmd_t   cmd;
  logic [7:0]        vga_r;
  logic [7:0]        vga_g;
  logic [7:0]        vga_b;
  logic              vga_hsync;
  logic              vga_vsync;
  logic              vga_blank_n;
  logic              vga_pix_en;
  drive_pkg::dir_t   direction;
  logic              orange_detected;
  logic [17:0]       orange_count;
  drive_pkg::drive_t drive_state;

  integer seed;
  int     errors;
  int     checks;

  // Model of the stored frame and of the next frame sent by the camera
  logic [11:0] model_mem [0:FRAME_PIX-1];
  logic [11:0] frame_next [0:FRAME_PIX-1];

  // Model of the locator results and the controller
  drive_pkg::dir_t        exp_dir;
  logic                   exp_det;
  int                     exp_count;
  drive_pkg::ctrl_state_t m_state;
  drive_pkg::drive_t      m_drive;

  camera_vision_top #(
    .FRAME_W(FRAME_W), .FRAME_H(FRAME_H),
    .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
    .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK),
    .ORANGE_MIN(ORANGE_MIN)
  ) i_camera_vision_top (
    .clk_50, .reset, .cam_vsync, .cam_href, .cam_pclk_en, .cam_data,
    .cmd_strobe, .cmd, .vga_r, .vga_g, .vga_b, .vga_hsync, .vga_vsync,
    .vga_blank_n, .vga_pix_en, .direction, .orange_detected, .orange_count,
    .drive_state);

  // 8 ns period
  always #4 clk_50 = ~clk_50;

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("ERROR %0t ns: %s expected 0x%0h, got 0x%0h", $time, what, expected, actual);
    end
  endtask

  task automatic abort_on_timeout(input string what);
    $display("Timeout: %s did not happen within %0d cycles", what, TIMEOUT);
    $display("Simulation FAILED");
    $finish;
  endtask

  function automatic int rand_below(input int n);
    return $unsigned($random(seed)) % n;
  endfunction

  // Channel expansion, n times 17
  function automatic logic [7:0] widen(input logic [3:0] n);
    return 8'(n * 17);
  endfunction

  // Orange box on the widened channels, all bounds inclusive
  function automatic bit orange_rule(input logic [11:0] p);
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
    r = widen(p[11:8]);
    g = widen(p[7:4]);
    b = widen(p[3:0]);
    return (r >= cam_pkg::ORANGE_R_MIN) && (g >= cam_pkg::ORANGE_G_MIN) &&
           (g <= cam_pkg::ORANGE_G_MAX) && (b <= cam_pkg::ORANGE_B_MAX);
  endfunction

  // Random colour forced out of the box
  function automatic logic [11:0] plain_pixel();
    logic [11:0] p;
    p = 12'($random(seed));
    if (orange_rule(p)) begin
      p[11] = 1'b0;
    end
    return p;
  endfunction

  function automatic logic [11:0] orange_pixel();
    logic [3:0] r;
    logic [3:0] g;
    logic [3:0] b;
    r = 4'(12 + rand_below(4));
    g = 4'(4 + rand_below(6));
    b = 4'(rand_below(5));
    return {r, g, b};
  endfunction

  // Roughly a quarter of the pixels orange, anywhere
  task automatic gen_mixed_frame();
    for (int i = 0; i < FRAME_PIX; i++) begin
      frame_next[i] = (rand_below(4) == 0) ? orange_pixel() : plain_pixel();
    end
  endtask

  // n orange pixels on distinct rows inside one third
  task automatic gen_target_frame(input int third, input int n);
    int r0;
    int c0;
    int row;
    int col;
    for (int i = 0; i < FRAME_PIX; i++) begin
      frame_next[i] = plain_pixel();
    end
    r0 = rand_below(FRAME_H);
    c0 = rand_below(THIRD_W);
    for (int k = 0; k < n; k++) begin
      row = (r0 + k) % FRAME_H;
      col = third * THIRD_W + (c0 + k) % THIRD_W;
      frame_next[row * FRAME_W + col] = orange_pixel();
    end
  endtask

  // Camera byte stream, red first then green and blue
  task automatic send_frame();
    logic [11:0] p;
    @(posedge clk_50);
    cam_vsync <= 1'b1;
    repeat (3) @(posedge clk_50);
    cam_vsync <= 1'b0;
    for (int y = 0; y < FRAME_H; y++) begin
      @(posedge clk_50);
      cam_href <= 1'b1;
      for (int x = 0; x < FRAME_W; x++) begin
        p = frame_next[y * FRAME_W + x];
        @(posedge clk_50);
        cam_pclk_en <= 1'b1;
        // High nibble of the first byte carries nothing
        cam_data    <= {4'($random(seed)), p[11:8]};
        @(posedge clk_50);
        cam_pclk_en <= 1'b0;
        @(posedge clk_50);
        cam_pclk_en <= 1'b1;
        cam_data    <= p[7:0];
        @(posedge clk_50);
        cam_pclk_en <= 1'b0;
      end
      @(posedge clk_50);
      cam_href <= 1'b0;
      repeat (2) @(posedge clk_50);
    end
    // Frozen capture keeps the old frame
    if (m_state != drive_pkg::ST_HOLD) begin
      for (int i = 0; i < FRAME_PIX; i++) begin
        model_mem[i] = frame_next[i];
      end
    end
    repeat (4) @(posedge clk_50);
  endtask

  // Thirds, total and tie order centre then left
  task automatic predict_locator();
    int l;
    int c;
    int r;
    int x;
    l = 0;
    c = 0;
    r = 0;
    for (int i = 0; i < FRAME_PIX; i++) begin
      x = i % FRAME_W;
      if (orange_rule(model_mem[i])) begin
        if (x < FRAME_W / 3) l++;
        else if (x >= (2 * FRAME_W) / 3) r++;
        else c++;
      end
    end
    exp_count = l + c + r;
    exp_det   = (exp_count >= ORANGE_MIN);
    if (!exp_det) exp_dir = drive_pkg::NONE;
    else if (c >= l && c >= r) exp_dir = drive_pkg::CENTER;
    else if (l >= r) exp_dir = drive_pkg::LEFT;
    else exp_dir = drive_pkg::RIGHT;
  endtask

  // Controller table on a frame end
  task automatic model_frame_end();
    if (m_state == drive_pkg::ST_SEARCH || m_state == drive_pkg::ST_TRACK) begin
      if (exp_det) begin
        m_state = drive_pkg::ST_TRACK;
        case (exp_dir)
          drive_pkg::LEFT:   m_drive = drive_pkg::DRV_LEFT;
          drive_pkg::CENTER: m_drive = drive_pkg::DRV_FORWARD;
          default:           m_drive = drive_pkg::DRV_RIGHT;
        endcase
      end else begin
        m_state = drive_pkg::ST_SEARCH;
        m_drive = drive_pkg::DRV_SPIN;
      end
    end else begin
      m_drive = drive_pkg::DRV_STOP;
    end
  endtask

  task automatic model_command(input drive_pkg::cmd_t c);
    if (c == drive_pkg::CMD_STOP) begin
      m_state = drive_pkg::ST_IDLE;
      m_drive = drive_pkg::DRV_STOP;
    end else if (c == drive_pkg::CMD_START &&
                 (m_state == drive_pkg::ST_IDLE || m_state == drive_pkg::ST_HOLD)) begin
      m_state = drive_pkg::ST_SEARCH;
      m_drive = drive_pkg::DRV_SPIN;
    end else if (c == drive_pkg::CMD_HOLD &&
                 (m_state == drive_pkg::ST_SEARCH || m_state == drive_pkg::ST_TRACK)) begin
      m_state = drive_pkg::ST_HOLD;
      m_drive = drive_pkg::DRV_STOP;
    end
  endtask

  // Issued right after a frame end so no frame_done lands close by
  task automatic issue_command(input drive_pkg::cmd_t c);
    model_command(c);
    @(posedge clk_50);
    cmd_strobe <= 1'b1;
    cmd        <= c;
    @(posedge clk_50);
    cmd_strobe <= 1'b0;
    @(negedge clk_50);
    check_value("drive_state after command", 32'(m_drive), 32'(drive_state));
  endtask

  task automatic wait_vsync_rise();
    logic prev;
    int   guard;
    logic done;
    prev  = vga_vsync;
    guard = 0;
    done  = 1'b0;
    while (!done) begin
      @(negedge clk_50);
      guard++;
      if (guard > TIMEOUT) abort_on_timeout("rise of vga_vsync");
      if (vga_vsync && !prev) done = 1'b1;
      prev = vga_vsync;
    end
  endtask

  // One clean displayed frame, then the locator and controller results
  task automatic check_frame();
    logic        prev;
    logic        hs_prev;
    logic        done;
    int          guard;
    int          idx;
    int          hs_rises;
    logic [11:0] p;
    logic [23:0] exp_rgb;
    wait_vsync_rise();
    prev     = 1'b1;
    hs_prev  = vga_hsync;
    done     = 1'b0;
    guard    = 0;
    idx      = 0;
    hs_rises = 0;
    while (!done) begin
      @(negedge clk_50);
      guard++;
      if (guard > TIMEOUT) abort_on_timeout("end of the displayed frame");
      if (vga_hsync && !hs_prev) hs_rises++;
      hs_prev = vga_hsync;
      if (vga_vsync && !prev) begin
        done = 1'b1;
      end else if (vga_pix_en && vga_blank_n) begin
        if (idx < FRAME_PIX) begin
          p = model_mem[idx];
          if (orange_rule(p)) begin
            exp_rgb = {cam_pkg::HIGHLIGHT_R, cam_pkg::HIGHLIGHT_G, cam_pkg::HIGHLIGHT_B};
          end else begin
            exp_rgb = {widen(p[11:8]), widen(p[7:4]), widen(p[3:0])};
          end
          check_value($sformatf("colour of pixel %0d", idx), 32'(exp_rgb),
                      32'({vga_r, vga_g, vga_b}));
        end
        idx++;
      end
      prev = vga_vsync;
    end
    check_value("active pixels per frame", FRAME_PIX, idx);
    check_value("hsync pulses per frame", V_TOTAL, hs_rises);
    predict_locator();
    model_frame_end();
    // frame_done plus the controller register
    repeat (4) @(negedge clk_50);
    check_value("direction", 32'(exp_dir), 32'(direction));
    check_value("orange_detected", 32'(exp_det), 32'(orange_detected));
    check_value("orange_count", exp_count, 32'(orange_count));
    check_value("drive_state after frame", 32'(m_drive), 32'(drive_state));
  endtask

  initial begin
    seed        = 32'h4663;
    errors      = 0;
    checks      = 0;
    clk_50      = 1'b0;
    reset       = 1'b1;
    cam_vsync   = 1'b0;
    cam_href    = 1'b0;
    cam_pclk_en = 1'b0;
    cam_data    = 8'h00;
    cmd_strobe  = 1'b0;
    cmd         = drive_pkg::CMD_STOP;
    m_state     = drive_pkg::ST_IDLE;
    m_drive     = drive_pkg::DRV_STOP;

    repeat (10) @(posedge clk_50);
    reset <= 1'b0;
    @(negedge clk_50);
    // Reset values
    check_value("vga_hsync", 0, 32'(vga_hsync));
    check_value("vga_vsync", 0, 32'(vga_vsync));
    check_value("vga_blank_n", 0, 32'(vga_blank_n));
    check_value("vga_pix_en", 0, 32'(vga_pix_en));
    check_value("direction", 32'(drive_pkg::NONE), 32'(direction));
    check_value("orange_detected", 0, 32'(orange_detected));
    check_value("orange_count", 0, 32'(orange_count));
    check_value("drive_state", 32'(drive_pkg::DRV_STOP), 32'(drive_state));

    // Mixed frames while idle
    repeat (3) begin
      gen_mixed_frame();
      send_frame();
      check_frame();
    end

    // Target in one third, count around the threshold
    repeat (5) begin
      gen_target_frame(rand_below(3), ORANGE_MIN - 3 + rand_below(7));
      send_frame();
      check_frame();
    end

    // Search, track, lose, stop
    issue_command(drive_pkg::CMD_START);
    gen_target_frame(rand_below(3), ORANGE_MIN + rand_below(4));
    send_frame();
    check_frame();
    gen_target_frame(0, 0);
    send_frame();
    check_frame();
    issue_command(drive_pkg::CMD_STOP);

    // Frozen capture keeps the earlier frame on screen
    issue_command(drive_pkg::CMD_START);
    gen_mixed_frame();
    send_frame();
    check_frame();
    issue_command(drive_pkg::CMD_HOLD);
    gen_mixed_frame();
    send_frame();
    check_frame();
    issue_command(drive_pkg::CMD_START);
    gen_mixed_frame();
    send_frame();
    check_frame();

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* camera_vision.f */
verilog/cam_pkg.sv
verilog/drive_pkg.sv
verilog/ov7670_capture.sv
verilog/frame_buffer.sv
verilog/vga_timing.sv
verilog/pixel_reader.sv
verilog/target_finder.sv
verilog/target_locator.sv
verilog/drive_controller.sv
verilog/camera_vision_top.sv
bench/tb_camera_vision.sv

/* verilog/cam_pkg.sv */
`default_nettype none

package cam_pkg;

  // One stored pixel in RGB444
  // Red sits in the top nibble and blue in the bottom one
  typedef struct packed {
    logic [3:0] r;
    logic [3:0] g;
    logic [3:0] b;
  } pixel12_t;

  // Orange box on the expanded 8-bit channels
  // All bounds are inclusive
  localparam logic [7:0] ORANGE_R_MIN = 8'hC0;
  localparam logic [7:0] ORANGE_G_MIN = 8'h40;
  localparam logic [7:0] ORANGE_G_MAX = 8'hA0;
  localparam logic [7:0] ORANGE_B_MAX = 8'h50;

  // Colour painted over every orange pixel
  localparam logic [7:0] HIGHLIGHT_R = 8'h00;
  localparam logic [7:0] HIGHLIGHT_G = 8'hFF;
  localparam logic [7:0] HIGHLIGHT_B = 8'h00;

  // Expansion of a 4-bit channel to 8 bits
  // Nibble n is repeated in both halves so the result is n times 17
  // 0x0 gives 0x00 and 0xF gives 0xFF
  function automatic logic [7:0] expand4(input logic [3:0] n);
    return {n, n};
  endfunction

endpackage

`default_nettype wire

/* verilog/camera_vision_top.sv */
`timescale 1ns/1ps
`default_nettype none

module camera_vision_top #(
  parameter int FRAME_W    = 320,
  parameter int FRAME_H    = 240,
  parameter int H_FRONT    = 8,
  parameter int H_SYNC     = 48,
  parameter int H_BACK     = 24,
  parameter int V_FRONT    = 2,
  parameter int V_SYNC     = 2,
  parameter int V_BACK     = 16,
  parameter int ORANGE_MIN = 64,
  localparam int ADDR_W    = $clog2(FRAME_W * FRAME_H)
) (
  input  logic              clk_50,
  input  logic              reset,
  input  logic              cam_vsync,
  input  logic              cam_href,
  input  logic              cam_pclk_en,
  input  logic [7:0]        cam_data,
  input  logic              cmd_strobe,
  input  drive_pkg::cmd_t   cmd,
  output logic [7:0]        vga_r,
  output logic [7:0]        vga_g,
  output logic [7:0]        vga_b,
  output logic              vga_hsync,
  output logic              vga_vsync,
  output logic              vga_blank_n,
  output logic              vga_pix_en,
  output drive_pkg::dir_t   direction,
  output logic              orange_detected,
  output logic [17:0]       orange_count,
  output drive_pkg::drive_t drive_state
);

  // Capture to frame buffer
  logic              wr_en;
  logic [ADDR_W-1:0] wr_addr;
  cam_pkg::pixel12_t wr_data;
  logic              capture_en;
  // Frame buffer to display
  logic [ADDR_W-1:0] rd_addr;
  cam_pkg::pixel12_t rd_data;
  // Raw scan timing
  logic              pix_en;
  logic              hsync;
  logic              vsync;
  logic              active;
  logic              line_start;
  // Expanded pixel stream
  logic [7:0]        red;
  logic [7:0]        green;
  logic [7:0]        blue;
  logic              px_en;
  logic              px_hsync;
  logic              px_vsync;
  logic              px_active;
  logic              px_line_start;
  // Detection results
  logic              is_orange;
  logic              out_line_start;
  logic              frame_done;

  ov7670_capture #(.FRAME_W(FRAME_W), .FRAME_H(FRAME_H)) i_capture (
    .clk_50, .reset, .cam_vsync, .cam_href, .cam_pclk_en, .cam_data,
    .capture_en, .wr_en, .wr_addr, .wr_data);

  frame_buffer #(.FRAME_W(FRAME_W), .FRAME_H(FRAME_H)) i_frame_buffer (
    .clk_50, .wr_en, .wr_addr, .wr_data, .rd_addr, .rd_data);

  vga_timing #(
    .FRAME_W(FRAME_W), .FRAME_H(FRAME_H),
    .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
    .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
  ) i_vga_timing (
    .clk_50, .reset, .pix_en, .hsync, .vsync, .active, .line_start);

  pixel_reader #(.FRAME_W(FRAME_W), .FRAME_H(FRAME_H)) i_pixel_reader (
    .clk_50, .reset, .pix_en, .hsync, .vsync, .active, .line_start,
    .rd_addr, .rd_data, .red, .green, .blue,
    .px_en, .px_hsync, .px_vsync, .px_active, .px_line_start);

  target_finder i_target_finder (
    .clk_50, .reset, .red, .green, .blue,
    .px_en, .px_hsync, .px_vsync, .px_active, .px_line_start,
    .vga_r, .vga_g, .vga_b, .vga_pix_en, .vga_hsync, .vga_vsync,
    .vga_blank_n, .is_orange, .out_line_start);

  target_locator #(.FRAME_W(FRAME_W), .ORANGE_MIN(ORANGE_MIN)) i_target_locator (
    .clk_50, .reset, .vga_pix_en, .vga_vsync, .vga_blank_n, .out_line_start,
    .is_orange, .frame_done, .direction, .orange_detected, .orange_count);

  drive_controller i_drive_controller (
    .clk_50, .reset, .cmd_strobe, .cmd, .frame_done, .direction,
    .orange_detected, .drive_state, .capture_en);

endmodule

`default_nettype wire

/* verilog/drive_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module drive_controller (
  input  logic                clk_50,
  input  logic                reset,
  input  logic                cmd_strobe,
  input  drive_pkg::cmd_t     cmd,
  input  logic                frame_done,
  input  drive_pkg::dir_t     direction,
  input  logic                orange_detected,
  output drive_pkg::drive_t   drive_state,
  output logic                capture_en
);

  drive_pkg::ctrl_state_t state;

  // Steering for a located target
  function automatic drive_pkg::drive_t steer(input drive_pkg::dir_t dir);
    case (dir)
      drive_pkg::LEFT:   return drive_pkg::DRV_LEFT;
      drive_pkg::CENTER: return drive_pkg::DRV_FORWARD;
      drive_pkg::RIGHT:  return drive_pkg::DRV_RIGHT;
      default:           return drive_pkg::DRV_SPIN;
    endcase
  endfunction

  always_ff @(posedge clk_50) begin
    if (reset) begin
      state       <= drive_pkg::ST_IDLE;
      drive_state <= drive_pkg::DRV_STOP;
    end else if (cmd_strobe) begin
      // Operator command wins over a frame result in the same cycle
      case (cmd)
        drive_pkg::CMD_STOP: begin
          state       <= drive_pkg::ST_IDLE;
          drive_state <= drive_pkg::DRV_STOP;
        end
        drive_pkg::CMD_START: begin
          if (state == drive_pkg::ST_IDLE || state == drive_pkg::ST_HOLD) begin
            state       <= drive_pkg::ST_SEARCH;
            drive_state <= drive_pkg::DRV_SPIN;
          end
        end
        drive_pkg::CMD_HOLD: begin
          if (state == drive_pkg::ST_SEARCH || state == drive_pkg::ST_TRACK) begin
            state       <= drive_pkg::ST_HOLD;
            drive_state <= drive_pkg::DRV_STOP;
          end
        end
        default: ;
      endcase
    end else if (frame_done) begin
      case (state)
        drive_pkg::ST_SEARCH, drive_pkg::ST_TRACK: begin
          if (orange_detected) begin
            state       <= drive_pkg::ST_TRACK;
            drive_state <= steer(direction);
          end else begin
            // Target lost or not yet seen so turn on the spot
            state       <= drive_pkg::ST_SEARCH;
            drive_state <= drive_pkg::DRV_SPIN;
          end
        end
        default: drive_state <= drive_pkg::DRV_STOP;
      endcase
    end
  end

  // Frame buffer is frozen only while holding
  assign capture_en = (state != drive_pkg::ST_HOLD);

  // Known state and wheels stopped whenever idle or holding
  a_state_legal: assert property (@(posedge clk_50) disable iff (reset)
    !$isunknown(state) &&
    (!(state inside {drive_pkg::ST_IDLE, drive_pkg::ST_HOLD}) ||
     drive_state == drive_pkg::DRV_STOP));

endmodule

`default_nettype wire

/* verilog/drive_pkg.sv */
`default_nettype none

package drive_pkg;

  // Side of the image holding the target
  // One-hot so the value can light three LEDs as it is
  typedef enum logic [2:0] {
    NONE   = 3'b000,
    LEFT   = 3'b100,
    CENTER = 3'b010,
    RIGHT  = 3'b001
  } dir_t;

  // Operator commands from the remote buttons
  typedef enum logic [1:0] {
    CMD_START = 2'd0,
    CMD_STOP  = 2'd1,
    CMD_HOLD  = 2'd2
  } cmd_t;

  // Motor command sent to the drive side
  typedef enum logic [2:0] {
    DRV_STOP    = 3'd0,
    DRV_FORWARD = 3'd1,
    DRV_LEFT    = 3'd2,
    DRV_RIGHT   = 3'd3,
    DRV_SPIN    = 3'd4
  } drive_t;

  // Control FSM states
  typedef enum logic [1:0] {
    ST_IDLE   = 2'd0,
    ST_SEARCH = 2'd1,
    ST_TRACK  = 2'd2,
    ST_HOLD   = 2'd3
  } ctrl_state_t;

endpackage

`default_nettype wire

/* verilog/frame_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_buffer #(
  parameter int FRAME_W = 320,
  parameter int FRAME_H = 240,
  localparam int ADDR_W = $clog2(FRAME_W * FRAME_H)
) (
  input  logic              clk_50,
  input  logic              wr_en,
  input  logic [ADDR_W-1:0] wr_addr,
  input  cam_pkg::pixel12_t wr_data,
  input  logic [ADDR_W-1:0] rd_addr,
  output cam_pkg::pixel12_t rd_data
);

  // One full frame of RGB444 pixels, maps onto block RAM
  cam_pkg::pixel12_t mem [0:FRAME_W*FRAME_H-1];

  // Camera write port
  always_ff @(posedge clk_50) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Display read port
  // Same-address collisions return the old word
  always_ff @(posedge clk_50) begin
    rd_data <= mem[rd_addr];
  end

endmodule

`default_nettype wire

/* verilog/ov7670_capture.sv */
`timescale 1ns/1ps
`default_nettype none

module ov7670_capture #(
  parameter int FRAME_W = 320,
  parameter int FRAME_H = 240,
  localparam int ADDR_W = $clog2(FRAME_W * FRAME_H)
) (
  input  logic              clk_50,
  input  logic              reset,
  input  logic              cam_vsync,
  input  logic              cam_href,
  input  logic              cam_pclk_en,
  input  logic [7:0]        cam_data,
  input  logic              capture_en,
  output logic              wr_en,
  output logic [ADDR_W-1:0] wr_addr,
  output cam_pkg::pixel12_t wr_data
);

  localparam int FRAME_SIZE = FRAME_W * FRAME_H;

  // High while the second byte of a pair is awaited
  logic            phase;
  logic            href_q;
  logic [3:0]      red_nib;
  // One bit wider than the RAM address so it can stop at FRAME_SIZE
  logic [ADDR_W:0] pix_addr;
  logic            first_byte;
  logic            in_frame;

  // A rising href always starts on a first byte
  assign first_byte = (cam_href && !href_q) || !phase;
  assign in_frame   = (pix_addr < FRAME_SIZE);

  always_ff @(posedge clk_50) begin
    if (reset) begin
      phase    <= 1'b0;
      href_q   <= 1'b0;
      pix_addr <= '0;
      wr_en    <= 1'b0;
    end else begin
      href_q <= cam_href;
      wr_en  <= 1'b0;
      if (cam_vsync) begin
        // Frame sync restarts the address and the byte pairing
        phase    <= 1'b0;
        pix_addr <= '0;
      end else if (cam_pclk_en && cam_href) begin
        if (first_byte) begin
          phase <= 1'b1;
        end else begin
          phase <= 1'b0;
          // Frozen capture still walks the address so the frame stays aligned
          wr_en <= capture_en && in_frame;
          if (in_frame) begin
            pix_addr <= pix_addr + 1'b1;
          end
        end
      end else if (cam_href && !href_q) begin
        phase <= 1'b0;
      end
    end
  end

  // Pixel packing
  always_ff @(posedge clk_50) begin
    if (cam_pclk_en && cam_href) begin
      if (first_byte) begin
        // Red arrives alone in the low nibble
        red_nib <= cam_data[3:0];
      end else begin
        wr_data <= {red_nib, cam_data};
        wr_addr <= pix_addr[ADDR_W-1:0];
      end
    end
  end

  // A write follows a camera strobe and stays inside the frame
  a_wr_in_frame: assert property (@(posedge clk_50) disable iff (reset)
    wr_en |-> (wr_addr < FRAME_SIZE) && $past(cam_pclk_en && cam_href));

endmodule

`default_nettype wire

/* verilog/pixel_reader.sv */
`timescale 1ns/1ps
`default_nettype none

module pixel_reader #(
  parameter int FRAME_W = 320,
  parameter int FRAME_H = 240,
  localparam int ADDR_W = $clog2(FRAME_W * FRAME_H)
) (
  input  logic              clk_50,
  input  logic              reset,
  input  logic              pix_en,
  input  logic              hsync,
  input  logic              vsync,
  input  logic              active,
  input  logic              line_start,
  output logic [ADDR_W-1:0] rd_addr,
  input  cam_pkg::pixel12_t rd_data,
  output logic [7:0]        red,
  output logic [7:0]        green,
  output logic [7:0]        blue,
  output logic              px_en,
  output logic              px_hsync,
  output logic              px_vsync,
  output logic              px_active,
  output logic              px_line_start
);

  // Timing bits waiting out the RAM read
  // Order is pix_en, hsync, vsync, active, line_start
  logic [4:0] tim_d1;

  always_ff @(posedge clk_50) begin
    if (reset) begin
      rd_addr <= '0;
      tim_d1  <= '0;
      {px_en, px_hsync, px_vsync, px_active, px_line_start} <= '0;
    end else begin
      // Scan order address, rewound during vertical sync
      if (vsync) begin
        rd_addr <= '0;
      end else if (pix_en && active) begin
        rd_addr <= rd_addr + 1'b1;
      end
      tim_d1 <= {pix_en, hsync, vsync, active, line_start};
      {px_en, px_hsync, px_vsync, px_active, px_line_start} <= tim_d1;
    end
  end

  // RAM data is valid one cycle after the address
  // Registered here together with the second timing stage
  always_ff @(posedge clk_50) begin
    red   <= cam_pkg::expand4(rd_data.r);
    green <= cam_pkg::expand4(rd_data.g);
    blue  <= cam_pkg::expand4(rd_data.b);
  end

endmodule

`default_nettype wire

/* verilog/target_finder.sv */
`timescale 1ns/1ps
`default_nettype none

module target_finder (
  input  logic       clk_50,
  input  logic       reset,
  input  logic [7:0] red,
  input  logic [7:0] green,
  input  logic [7:0] blue,
  input  logic       px_en,
  input  logic       px_hsync,
  input  logic       px_vsync,
  input  logic       px_active,
  input  logic       px_line_start,
  output logic [7:0] vga_r,
  output logic [7:0] vga_g,
  output logic [7:0] vga_b,
  output logic       vga_pix_en,
  output logic       vga_hsync,
  output logic       vga_vsync,
  output logic       vga_blank_n,
  output logic       is_orange,
  output logic       out_line_start
);

  logic in_box;

  // Orange box on the expanded channels
  // Red above its floor, green inside its band, blue under its ceiling
  assign in_box = (red >= cam_pkg::ORANGE_R_MIN) &&
                  (green >= cam_pkg::ORANGE_G_MIN) &&
                  (green <= cam_pkg::ORANGE_G_MAX) &&
                  (blue <= cam_pkg::ORANGE_B_MAX);

  always_ff @(posedge clk_50) begin
    if (reset) begin
      vga_r          <= '0;
      vga_g          <= '0;
      vga_b          <= '0;
      vga_pix_en     <= 1'b0;
      vga_hsync      <= 1'b0;
      vga_vsync      <= 1'b0;
      vga_blank_n    <= 1'b0;
      is_orange      <= 1'b0;
      out_line_start <= 1'b0;
    end else begin
      // Timing bits travel with the colour through this stage
      vga_pix_en     <= px_en;
      vga_hsync      <= px_hsync;
      vga_vsync      <= px_vsync;
      vga_blank_n    <= px_active;
      out_line_start <= px_line_start;
      // Only pixels inside the picture can be targets
      is_orange      <= px_active && in_box;
      if (!px_active) begin
        // Blanking is black
        vga_r <= '0;
        vga_g <= '0;
        vga_b <= '0;
      end else if (in_box) begin
        vga_r <= cam_pkg::HIGHLIGHT_R;
        vga_g <= cam_pkg::HIGHLIGHT_G;
        vga_b <= cam_pkg::HIGHLIGHT_B;
      end else begin
        vga_r <= red;
        vga_g <= green;
        vga_b <= blue;
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/target_locator.sv */
`timescale 1ns/1ps
`default_nettype none

module target_locator #(
  parameter int FRAME_W    = 320,
  parameter int ORANGE_MIN = 64
) (
  input  logic             clk_50,
  input  logic             reset,
  input  logic             vga_pix_en,
  input  logic             vga_vsync,
  input  logic             vga_blank_n,
  input  logic             out_line_start,
  input  logic             is_orange,
  output logic             frame_done,
  output drive_pkg::dir_t  direction,
  output logic             orange_detected,
  output logic [17:0]      orange_count
);

  // Column borders of the three image thirds
  localparam int LEFT_END    = FRAME_W / 3;
  localparam int RIGHT_START = (2 * FRAME_W) / 3;
  localparam int X_W         = $clog2(FRAME_W + 1);

  logic [X_W-1:0] x_cnt;
  logic [X_W-1:0] col;
  logic [17:0]    cnt_l;
  logic [17:0]    cnt_c;
  logic [17:0]    cnt_r;
  logic [19:0]    total;
  logic           vsync_q;
  logic           frame_end;
  logic           hit;

  // Per-third counters stop at full scale
  function automatic logic [17:0] sat_inc(input logic [17:0] v);
    return (v == '1) ? v : v + 18'd1;
  endfunction

  // First pixel of a line is column zero
  assign col       = out_line_start ? '0 : x_cnt;
  assign hit       = vga_pix_en && vga_blank_n && is_orange;
  assign frame_end = vga_vsync && !vsync_q;
  assign total     = 20'(cnt_l) + 20'(cnt_c) + 20'(cnt_r);

  always_ff @(posedge clk_50) begin
    if (reset) begin
      vsync_q         <= 1'b0;
      x_cnt           <= '0;
      cnt_l           <= '0;
      cnt_c           <= '0;
      cnt_r           <= '0;
      frame_done      <= 1'b0;
      direction       <= drive_pkg::NONE;
      orange_detected <= 1'b0;
      orange_count    <= '0;
    end else begin
      vsync_q    <= vga_vsync;
      frame_done <= frame_end;
      // Column of the next pixel event
      if (vga_pix_en) begin
        if (out_line_start) begin
          x_cnt <= 1'b1;
        end else if (vga_blank_n) begin
          x_cnt <= x_cnt + 1'b1;
        end
      end
      if (frame_end) begin
        // Latch the frame result and start a fresh count
        cnt_l <= '0;
        cnt_c <= '0;
        cnt_r <= '0;
        orange_count <= (total > 20'h3FFFF) ? '1 : total[17:0];
        if (total >= ORANGE_MIN) begin
          orange_detected <= 1'b1;
          // Ties favour centre first and then left
          if (cnt_c >= cnt_l && cnt_c >= cnt_r) begin
            direction <= drive_pkg::CENTER;
          end else if (cnt_l >= cnt_r) begin
            direction <= drive_pkg::LEFT;
          end else begin
            direction <= drive_pkg::RIGHT;
          end
        end else begin
          orange_detected <= 1'b0;
          direction       <= drive_pkg::NONE;
        end
      end else if (hit) begin
        if (col < LEFT_END) begin
          cnt_l <= sat_inc(cnt_l);
        end else if (col >= RIGHT_START) begin
          cnt_r <= sat_inc(cnt_r);
        end else begin
          cnt_c <= sat_inc(cnt_c);
        end
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/vga_timing.sv */
`timescale 1ns/1ps
`default_nettype none

module vga_timing #(
  parameter int FRAME_W = 320,
  parameter int FRAME_H = 240,
  parameter int H_FRONT = 8,
  parameter int H_SYNC  = 48,
  parameter int H_BACK  = 24,
  parameter int V_FRONT = 2,
  parameter int V_SYNC  = 2,
  parameter int V_BACK  = 16
) (
  input  logic clk_50,
  input  logic reset,
  output logic pix_en,
  output logic hsync,
  output logic vsync,
  output logic active,
  output logic line_start
);

  localparam int H_TOTAL  = FRAME_W + H_FRONT + H_SYNC + H_BACK;
  localparam int V_TOTAL  = FRAME_H + V_FRONT + V_SYNC + V_BACK;
  localparam int HS_START = FRAME_W + H_FRONT;
  localparam int VS_START = FRAME_H + V_FRONT;

  logic [$clog2(H_TOTAL)-1:0] h_cnt;
  logic [$clog2(V_TOTAL)-1:0] v_cnt;

  always_ff @(posedge clk_50) begin
    if (reset) begin
      pix_en <= 1'b0;
      h_cnt  <= '0;
      v_cnt  <= '0;
    end else begin
      // Pixel rate is half of clk_50
      pix_en <= !pix_en;
      if (pix_en) begin
        if (h_cnt == H_TOTAL - 1) begin
          h_cnt <= '0;
          if (v_cnt == V_TOTAL - 1) begin
            v_cnt <= '0;
          end else begin
            v_cnt <= v_cnt + 1'b1;
          end
        end else begin
          h_cnt <= h_cnt + 1'b1;
        end
      end
    end
  end

  // Visible area sits at the start of each line and frame
  assign active     = (h_cnt < FRAME_W) && (v_cnt < FRAME_H);
  // Sync pulses are active high
  assign hsync      = (h_cnt >= HS_START) && (h_cnt < HS_START + H_SYNC);
  assign vsync      = (v_cnt >= VS_START) && (v_cnt < VS_START + V_SYNC);
  assign line_start = (h_cnt == 0);

  a_cnt_range: assert property (@(posedge clk_50) disable iff (reset)
    (h_cnt < H_TOTAL) && (v_cnt < V_TOTAL));

endmodule

`default_nettype wire
